// File: design/screenPkg.sv
//##################################################
// screen geometry, coordinate types and colours of
// the snake engine, shared by the RTL and testbench
// modules take it with a wildcard import
//##################################################

package screenPkg;

    // framebuffer size in pixels
    localparam int screenWidth = 160;
    localparam int screenHeight = 120;

    // coordinate widths follow from the framebuffer size
    typedef logic [$clog2(screenWidth)-1:0] coordX;
    typedef logic [$clog2(screenHeight)-1:0] coordY;

    // one bit per channel, red in the msb
    typedef logic [2:0] pixelColor;

    // square blocks, edge in pixels
    localparam int blockSize = 10;

    // count within one block edge
    typedef logic [3:0] blockOffset;

    // apple never moves
    localparam coordX appleX = 8'd30;
    localparam coordY appleY = 7'd30;

    localparam pixelColor appleColor = 3'b100;
    localparam pixelColor eraseColor = 3'b000;

    // head after reset, segment k sits blockSize*k below
    localparam coordX startX = 8'd80;
    localparam coordY startY = 7'd60;

endpackage

// File: design/gamePkg.sv
//##################################################
// game state types: steering direction and the
// phases of the frame paint sequencer
//##################################################

package gamePkg;

    // direction latched from the keys
    // none keeps the head in place
    typedef enum logic [2:0]
    {
        dirNone,
        dirRight,
        dirDown,
        dirUp,
        dirLeft
    } steerDir;

    // sequencer phases, one frame runs apple to move
    typedef enum logic [2:0]
    {
        phaseIdle,
        phaseApple,
        phaseDraw,
        phaseWaitTick,
        phaseErase,
        phaseCheck,
        phaseMove,
        phaseOver
    } paintPhase;

endpackage

// File: design/frameTicker.sv
//##################################################
// frame tick generator, one-cycle pulse every
// tickCycles clocks to pace the game
//##################################################

`timescale 1ns/1ns

module frameTicker
#(
    parameter int tickCycles = 2**20
)
(
    input  logic Clock,
    input  logic reset,
    output logic frameTick
);

    localparam int countBits = (tickCycles > 1) ? $clog2(tickCycles) : 1;
    localparam logic [countBits-1:0] lastCount = countBits'(tickCycles - 1);

    logic [countBits-1:0] count;

    // free running, wraps at tickCycles-1
    always_ff @(posedge Clock)
    begin
        if (reset)
            count <= '0;
        else if (frameTick)
            count <= '0;
        else
            count <= count + 1'b1;
    end

    // pulse on the wrap cycle
    assign frameTick = (count == lastCount);

endmodule

// File: design/headSteer.sv
//##################################################
// steering: latches the pressed key by priority and
// gives the head position one pixel further on
//##################################################

`timescale 1ns/1ns

module headSteer
    import screenPkg::*, gamePkg::*;
(
    input  logic  Clock,
    input  logic  reset,
    input  logic  keyRight,
    input  logic  keyDown,
    input  logic  keyUp,
    input  logic  keyLeft,
    input  coordX headX,
    input  coordY headY,
    output coordX nextX,
    output coordY nextY
);

    steerDir dir;

    // priority right, down, up, left
    // no key held keeps the last direction
    always_ff @(posedge Clock)
    begin
        if (reset)
            dir <= dirNone;
        else if (keyRight)
            dir <= dirRight;
        else if (keyDown)
            dir <= dirDown;
        else if (keyUp)
            dir <= dirUp;
        else if (keyLeft)
            dir <= dirLeft;
    end

    // one pixel step, wraps at the coordinate width
    always_comb
    begin
        nextX = headX;
        nextY = headY;
        case (dir)
            dirRight: nextX = headX + 1'b1;
            dirDown:  nextY = headY + 1'b1;
            dirUp:    nextY = headY - 1'b1;
            dirLeft:  nextX = headX - 1'b1;
            // none, head stays put
            default:  nextY = headY;
        endcase
    end

endmodule

// File: design/snakeBody.sv
//##################################################
// snake body: history of past head positions, one
// entry per move; segment k is entry k*blockSize
// also flags the head running into its own body
//##################################################

`timescale 1ns/1ns

module snakeBody
    import screenPkg::*;
#(
    parameter int snakeLength = 6
)
(
    input  logic                           Clock,
    input  logic                           reset,
    input  logic                           moveStrobe,
    input  coordX                          nextX,
    input  coordY                          nextY,
    input  logic [$clog2(snakeLength)-1:0] segIndex,
    output coordX                          headX,
    output coordY                          headY,
    output coordX                          segX,
    output coordY                          segY,
    output logic                           selfHit
);

    // one history entry per pixel of travel
    localparam int depth = snakeLength * blockSize;

    coordX historyX [depth];
    coordY historyY [depth];

    // true when two block corners are closer than a block in one axis
    function automatic logic nearBy(input int a, input int b);
        return ((a - b) < blockSize) && ((b - a) < blockSize);
    endfunction

    // reset lays the segments out below the head
    // entries within one block share a position
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            for (int j = 0; j < depth; j++)
            begin
                historyX[j] <= startX;
                historyY[j] <= coordY'(int'(startY) + blockSize * (j / blockSize));
            end
        end
        else if (moveStrobe)
        begin
            // new head in front, the rest trails by one
            historyX[0] <= nextX;
            historyY[0] <= nextY;
            for (int j = 1; j < depth; j++)
            begin
                historyX[j] <= historyX[j-1];
                historyY[j] <= historyY[j-1];
            end
        end
    end

    assign headX = historyX[0];
    assign headY = historyY[0];

    // corner of the selected segment
    assign segX = historyX[int'(segIndex) * blockSize];
    assign segY = historyY[int'(segIndex) * blockSize];

    // segment 1 always touches the head, so start at 2
    always_comb
    begin
        selfHit = 1'b0;
        for (int k = 2; k < snakeLength; k++)
        begin
            if (nearBy(int'(historyX[0]), int'(historyX[k*blockSize])) &&
                nearBy(int'(historyY[0]), int'(historyY[k*blockSize])))
                selfHit = 1'b1;
        end
    end

endmodule

// File: design/blockPainter.sv
//##################################################
// frame sequencer: apple, draw, wait, erase, check,
// move; walks each block row by row and feeds the
// pixel write register of the valid/ready handshake
//##################################################

`timescale 1ns/1ns

module blockPainter
    import screenPkg::*, gamePkg::*;
#(
    parameter int snakeLength = 6
)
(
    input  logic                           Clock,
    input  logic                           reset,
    input  logic                           start,
    input  logic                           frameTick,
    input  screenPkg::pixelColor           colorSel,
    input  coordX                          segX,
    input  coordY                          segY,
    input  logic                           selfHit,
    output logic [$clog2(snakeLength)-1:0] segIndex,
    output logic                           moveStrobe,
    output logic                           gameOver,
    output coordX                          pixelX,
    output coordY                          pixelY,
    output screenPkg::pixelColor           pixelColor,
    output logic                           pixelValid,
    input  logic                           pixelReady
);

    localparam int segBits = $clog2(snakeLength);
    localparam logic [segBits-1:0] lastSegment = segBits'(snakeLength - 1);
    localparam blockOffset lastOffset = blockOffset'(blockSize - 1);

    paintPhase phase;

    // offsets inside the current block, x fastest
    blockOffset offX;
    blockOffset offY;

    logic selecting;
    logic outReady;
    logic accept;
    logic lastCol;
    logic lastRow;
    logic lastSeg;
    coordX cornerX;
    coordY cornerY;
    screenPkg::pixelColor nextColor;

    always_comb
    begin
        // phases that put out pixels
        selecting = (phase == phaseApple) || (phase == phaseDraw) || (phase == phaseErase);
        // register empty or draining this cycle
        outReady = !pixelValid || pixelReady;
        accept = selecting && outReady;
        lastCol = (offX == lastOffset);
        lastRow = (offY == lastOffset);
        lastSeg = (segIndex == lastSegment);
        // apple corner is fixed, segments come from the body
        cornerX = (phase == phaseApple) ? appleX : segX;
        cornerY = (phase == phaseApple) ? appleY : segY;
        case (phase)
            phaseApple: nextColor = appleColor;
            phaseDraw:  nextColor = colorSel;
            default:    nextColor = eraseColor;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            phase <= phaseIdle;
            segIndex <= '0;
            offX <= '0;
            offY <= '0;
        end
        else
        begin
            case (phase)
                phaseIdle:
                    if (start && frameTick)
                        phase <= phaseApple;
                phaseApple, phaseDraw, phaseErase:
                    // counters step only when a pixel is taken
                    if (accept)
                    begin
                        if (!lastCol)
                            offX <= offX + 1'b1;
                        else
                        begin
                            offX <= '0;
                            if (!lastRow)
                                offY <= offY + 1'b1;
                            else
                            begin
                                // block done
                                offY <= '0;
                                if (phase == phaseApple)
                                    phase <= phaseDraw;
                                else if (!lastSeg)
                                    segIndex <= segIndex + 1'b1;
                                else
                                begin
                                    segIndex <= '0;
                                    phase <= (phase == phaseDraw) ? phaseWaitTick : phaseCheck;
                                end
                            end
                        end
                    end
                // frame stays on screen until the next tick
                phaseWaitTick:
                    if (frameTick)
                        phase <= phaseErase;
                phaseCheck:
                    phase <= selfHit ? phaseOver : phaseMove;
                // body shifts this cycle, next frame starts right after
                phaseMove:
                    phase <= phaseApple;
                // game over holds until reset
                default:
                    phase <= phaseOver;
            endcase
        end
    end

    // handshake valid, a pending write always completes
    always_ff @(posedge Clock)
    begin
        if (reset)
            pixelValid <= 1'b0;
        else if (outReady)
            pixelValid <= selecting;
    end

    // write payload, held while the framebuffer stalls
    always_ff @(posedge Clock)
    begin
        if (accept)
        begin
            pixelX <= cornerX + coordX'(offX);
            pixelY <= cornerY + coordY'(offY);
            pixelColor <= nextColor;
        end
    end

    assign moveStrobe = (phase == phaseMove);
    assign gameOver = (phase == phaseOver);

endmodule

// File: design/snakeGame.sv
//##################################################
// snake engine top: ticker paces the sequencer,
// steering and body act on its move strobe
// pixels leave as valid/ready framebuffer writes
//##################################################

`timescale 1ns/1ns

module snakeGame
    import screenPkg::*;
#(
    parameter int snakeLength = 6,
    parameter int tickCycles = 2**20
)
(
    input  logic                 Clock,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 keyRight,
    input  logic                 keyDown,
    input  logic                 keyUp,
    input  logic                 keyLeft,
    input  screenPkg::pixelColor colorSel,
    output coordX                pixelX,
    output coordY                pixelY,
    output screenPkg::pixelColor pixelColor,
    output logic                 pixelValid,
    input  logic                 pixelReady,
    output logic                 gameOver
);

    logic frameTick;
    logic moveStrobe;
    logic selfHit;
    coordX headX;
    coordY headY;
    coordX nextX;
    coordY nextY;
    coordX segX;
    coordY segY;
    logic [$clog2(snakeLength)-1:0] segIndex;

    // frame pacing
    frameTicker #(
        .tickCycles(tickCycles)
    ) u_frameTicker (
        .Clock(Clock),
        .reset(reset),
        .frameTick(frameTick)
    );

    // direction and next head position
    headSteer u_headSteer (
        .Clock(Clock),
        .reset(reset),
        .keyRight(keyRight),
        .keyDown(keyDown),
        .keyUp(keyUp),
        .keyLeft(keyLeft),
        .headX(headX),
        .headY(headY),
        .nextX(nextX),
        .nextY(nextY)
    );

    // position history and collision
    snakeBody #(
        .snakeLength(snakeLength)
    ) u_snakeBody (
        .Clock(Clock),
        .reset(reset),
        .moveStrobe(moveStrobe),
        .nextX(nextX),
        .nextY(nextY),
        .segIndex(segIndex),
        .headX(headX),
        .headY(headY),
        .segX(segX),
        .segY(segY),
        .selfHit(selfHit)
    );

    // frame sequencer and pixel output
    blockPainter #(
        .snakeLength(snakeLength)
    ) u_blockPainter (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .frameTick(frameTick),
        .colorSel(colorSel),
        .segX(segX),
        .segY(segY),
        .selfHit(selfHit),
        .segIndex(segIndex),
        .moveStrobe(moveStrobe),
        .gameOver(gameOver),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColor(pixelColor),
        .pixelValid(pixelValid),
        .pixelReady(pixelReady)
    );

endmodule

// File: testbench/snakeGameTb.sv
//##################################################
// testbench for the snake engine: drives keys and
// random back-pressure, predicts each pixel write
// with a reference model and compares on transfer
//##################################################

`timescale 1ns/1ns

module snakeGameTb
    import screenPkg::*, gamePkg::*;
();

    localparam int snakeLen = 6;
    localparam int tickLen = 64;
    localparam int histDepth = snakeLen * blockSize;
    localparam int blockPixels = blockSize * blockSize;
    localparam int frameWrites = blockPixels * (1 + 2 * snakeLen);
    localparam int waitLimit = 20000;
    localparam int overLimit = 8;
    localparam int idleCycles = 500;

    // part of a frame
    localparam int partApple = 0;
    localparam int partDraw = 1;
    localparam int partErase = 2;

    // key vectors, order right down up left
    localparam logic [3:0] keyR = 4'b1000;
    localparam logic [3:0] keyD = 4'b0100;
    localparam logic [3:0] keyU = 4'b0010;
    localparam logic [3:0] keyL = 4'b0001;

    typedef struct packed
    {
        coordX x;
        coordY y;
        pixelColor c;
    } pixelWrite;

    typedef coordX histXArr [histDepth];
    typedef coordY histYArr [histDepth];

    logic Clock;
    logic reset;
    logic start;
    logic keyRight;
    logic keyDown;
    logic keyUp;
    logic keyLeft;
    pixelColor colorSel;
    coordX outX;
    coordY outY;
    pixelColor outColor;
    logic outValid;
    logic pixelReady;
    logic gameOver;
    logic readyRandom;

    // model state, only touched at frame boundaries
    histXArr modelX;
    histYArr modelY;
    steerDir modelDir;
    pixelWrite expected[$];
    int writesSeen;

    // stall tracking for the handshake rules
    logic stalled;
    pixelWrite heldWrite;

    snakeGame #(
        .snakeLength(snakeLen),
        .tickCycles(tickLen)
    ) u_snakeGame (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .keyRight(keyRight),
        .keyDown(keyDown),
        .keyUp(keyUp),
        .keyLeft(keyLeft),
        .colorSel(colorSel),
        .pixelX(outX),
        .pixelY(outY),
        .pixelColor(outColor),
        .pixelValid(outValid),
        .pixelReady(pixelReady),
        .gameOver(gameOver)
    );

    initial
    begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    // framebuffer back-pressure, coin flip when enabled
    initial
    begin
        void'($urandom(32'hc89d_9fa6));
        pixelReady = 1'b1;
        forever
        begin
            @(negedge Clock);
            pixelReady = readyRandom ? (($urandom % 2) == 1) : 1'b1;
        end
    end

    task automatic abortRun();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkValue(input string what, input int got, input int want);
        if (got != want)
        begin
            $display("ERR at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
            abortRun();
        end
    endtask

    // expected write number num of one frame part
    function automatic pixelWrite expectedPixel(input histXArr hx, input histYArr hy,
                                                input int part, input int num,
                                                input pixelColor drawColor);
        pixelWrite p;
        int seg;
        int off;
        coordX cx;
        coordY cy;
        seg = num / blockPixels;
        off = num % blockPixels;
        if (part == partApple)
        begin
            cx = appleX;
            cy = appleY;
            p.c = appleColor;
        end
        else
        begin
            // segment k is history entry k blocks back
            cx = hx[seg * blockSize];
            cy = hy[seg * blockSize];
            p.c = (part == partDraw) ? drawColor : eraseColor;
        end
        // row by row, x fastest, wrapping at the coordinate width
        p.x = cx + coordX'(off % blockSize);
        p.y = cy + coordY'(off / blockSize);
        return p;
    endfunction

    // head block overlapping segment 2 or later
    function automatic logic predictHit();
        logic hit;
        int dx;
        int dy;
        hit = 1'b0;
        for (int k = 2; k < snakeLen; k++)
        begin
            dx = int'(modelX[0]) - int'(modelX[k * blockSize]);
            dy = int'(modelY[0]) - int'(modelY[k * blockSize]);
            if (dx < blockSize && dx > -blockSize && dy < blockSize && dy > -blockSize)
                hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic initModel();
        for (int j = 0; j < histDepth; j++)
        begin
            modelX[j] = startX;
            modelY[j] = coordY'(int'(startY) + blockSize * (j / blockSize));
        end
        modelDir = dirNone;
    endtask

    // direction by key priority, then one pixel step and a history shift
    task automatic stepModel();
        coordX nx;
        coordY ny;
        if (keyRight)
            modelDir = dirRight;
        else if (keyDown)
            modelDir = dirDown;
        else if (keyUp)
            modelDir = dirUp;
        else if (keyLeft)
            modelDir = dirLeft;
        nx = modelX[0];
        ny = modelY[0];
        case (modelDir)
            dirRight: nx = nx + 1'b1;
            dirDown:  ny = ny + 1'b1;
            dirUp:    ny = ny - 1'b1;
            dirLeft:  nx = nx - 1'b1;
            default:  ny = modelY[0];
        endcase
        for (int j = histDepth - 1; j > 0; j--)
        begin
            modelX[j] = modelX[j-1];
            modelY[j] = modelY[j-1];
        end
        modelX[0] = nx;
        modelY[0] = ny;
    endtask

    task automatic setKeys(input logic [3:0] keys);
        {keyRight, keyDown, keyUp, keyLeft} = keys;
    endtask

    task automatic resetDut();
        reset = 1'b1;
        start = 1'b0;
        setKeys(4'b0000);
        repeat (16) @(negedge Clock);
        reset = 1'b0;
        initModel();
    endtask

    task automatic waitWrites(input int target, input string what);
        int cycles;
        cycles = 0;
        while (writesSeen < target)
        begin
            @(negedge Clock);
            cycles++;
            if (cycles > waitLimit)
            begin
                $display("timeout while waiting for the %s writes", what);
                abortRun();
            end
        end
    endtask

    task automatic queueFrame();
        for (int i = 0; i < blockPixels; i++)
            expected.push_back(expectedPixel(modelX, modelY, partApple, i, colorSel));
        for (int i = 0; i < snakeLen * blockPixels; i++)
            expected.push_back(expectedPixel(modelX, modelY, partDraw, i, colorSel));
        for (int i = 0; i < snakeLen * blockPixels; i++)
            expected.push_back(expectedPixel(modelX, modelY, partErase, i, colorSel));
    endtask

    // one frame; new keys go in after the apple, far from any move
    task automatic runFrame(input logic newKeys, input logic [3:0] keys, output logic over);
        int base;
        base = writesSeen;
        queueFrame();
        waitWrites(base + blockPixels, "apple");
        if (newKeys)
            setKeys(keys);
        waitWrites(base + frameWrites, "frame");
        over = predictHit();
        // last erase write is out, so the check phase is behind us
        checkValue("gameOver after the frame", int'(gameOver), int'(over));
        if (!over)
            stepModel();
    endtask

    task automatic playFrames(input int count, input logic newKeys, input logic [3:0] keys);
        int n;
        logic over;
        over = 1'b0;
        n = 0;
        while (n < count && !over)
        begin
            runFrame(newKeys && (n == 0), keys, over);
            n++;
        end
    endtask

    task automatic checkIdle(input int cycles, input logic overLevel);
        int base;
        base = writesSeen;
        repeat (cycles)
        begin
            @(negedge Clock);
            checkValue("gameOver while idle", int'(gameOver), int'(overLevel));
        end
        checkValue("writes while idle", writesSeen - base, 0);
    endtask

    task automatic expectGameOver();
        int cycles;
        cycles = 0;
        while (!gameOver)
        begin
            @(negedge Clock);
            cycles++;
            if (cycles > overLimit)
            begin
                $display("gameOver did not rise after the collision check");
                abortRun();
            end
        end
        checkIdle(idleCycles, 1'b1);
    endtask

    // comparing process, every transfer against the next expected write
    always @(posedge Clock)
    begin
        pixelWrite got;
        pixelWrite want;
        got = '{x: outX, y: outY, c: outColor};
        // payload frozen while the framebuffer stalls
        if (stalled)
        begin
            checkValue("pixelValid under back-pressure", int'(outValid), 1);
            checkValue("held pixel word", int'(got), int'(heldWrite));
        end
        stalled <= outValid && !pixelReady && !reset;
        heldWrite <= got;
        // writes cut off by a reset are not part of any frame
        if (outValid && pixelReady && !reset)
        begin
            if (expected.size() == 0)
            begin
                $display("pixel write at x %0d y %0d arrived when none was due", outX, outY);
                abortRun();
            end
            want = expected.pop_front();
            checkValue("pixel x", int'(outX), int'(want.x));
            checkValue("pixel y", int'(outY), int'(want.y));
            checkValue("pixel colour", int'(outColor), int'(want.c));
            writesSeen <= writesSeen + 1;
        end
    end

    initial
    begin
        reset = 1'b1;
        start = 1'b0;
        setKeys(4'b0000);
        colorSel = 3'b010;
        readyRandom = 1'b0;
        resetDut();

        // nothing happens before start
        checkIdle(idleCycles, 1'b0);
        start = 1'b1;

        // first frame, no key, ready always high
        playFrames(1, 1'b0, 4'b0000);

        // climb past the top row under back-pressure
        readyRandom = 1'b1;
        playFrames(75, 1'b1, keyU);
        // up outranks left
        playFrames(3, 1'b1, keyU | keyL);

        // right, down over up, then back left into the body
        resetDut();
        colorSel = 3'b011;
        start = 1'b1;
        playFrames(25, 1'b1, keyR);
        playFrames(2, 1'b1, keyD | keyU);
        playFrames(40, 1'b1, keyL);
        expectGameOver();

        // heading down runs straight into segment 2
        resetDut();
        colorSel = 3'b001;
        setKeys(keyD);
        start = 1'b1;
        playFrames(10, 1'b0, 4'b0000);
        expectGameOver();

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: compile.f
design/screenPkg.sv
design/gamePkg.sv
design/frameTicker.sv
design/headSteer.sv
design/snakeBody.sv
design/blockPainter.sv
design/snakeGame.sv
testbench/snakeGameTb.sv

// File: Makefile
# Verilator build and run of the snake engine testbench
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= snakeGameTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
FAIL_TEXT ?= Result: FAILED
PASS_TEXT ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
